//--- fp_format_pkg.sv
`default_nettype none

// IEEE 754 single-precision format
// Field widths, bias, special encodings and exception flags
package fp_format_pkg;

  // ====================
  // Field widths
  // ====================

  // Exponent and stored fraction
  localparam int exp_bits  = 8;
  localparam int frac_bits = 23;

  // Mantissa including the hidden bit
  localparam int mant_bits = frac_bits + 1;

  // Full 24x24 mantissa product
  localparam int prod_bits = 2 * mant_bits;

  // Signed working exponent
  // Two extra bits leave room for overflow above 255 and underflow below 1
  localparam int exp_ext_bits = exp_bits + 2;

  // ====================
  // Encodings
  // ====================

  localparam int exp_bias = 127;

  // All-ones exponent marks infinity and NaN
  localparam logic [exp_bits-1:0] exp_max = '1;

  // Sign, exponent, fraction from MSB down
  typedef struct packed {
    logic                 sign;
    logic [exp_bits-1:0]  exp;
    logic [frac_bits-1:0] frac;
  } fp32_t;

  // Quiet NaN, positive, only the top fraction bit set
  localparam fp32_t canonical_nan = '{
    sign: 1'b0,
    exp:  exp_max,
    frac: {1'b1, {(frac_bits - 1){1'b0}}}
  };

  // Largest finite magnitude, exponent 254 and all fraction bits set
  localparam logic [exp_bits+frac_bits-1:0] max_finite_mag = {
    exp_max - 1'b1,
    {frac_bits{1'b1}}
  };

  // Exception flags in RISC-V fflags bit order, nv at bit 4
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

endpackage

`default_nettype wire

//--- fmul_pipe_pkg.sv
`default_nettype none

// Multiplier pipeline geometry and stage payloads
package fmul_pipe_pkg;

  // RISC-V rounding modes, codes 5 to 7 fall back to RNE
  typedef enum logic [2:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } round_mode_e;

  // ====================
  // Step geometry
  // ====================

  // Bits of mantissa B consumed by each accumulation step
  localparam int slice_bits = 6;

  // Steps needed to cover the whole mantissa
  localparam int mac_steps = fp_format_pkg::mant_bits / slice_bits;

  // Unpack, then the steps, then two rounding stages
  localparam int fmul_latency = 1 + mac_steps + 2;

  // ====================
  // Stage payloads
  // ====================

  // Side band carried unchanged through the steps
  typedef struct packed {
    logic                                          sign;
    logic signed [fp_format_pkg::exp_ext_bits-1:0] exp;
    round_mode_e                                   rm;
    // NaN and infinity cases resolved in unpack
    logic                                          is_special;
    fp_format_pkg::fp32_t                          special_result;
    logic                                          special_invalid;
    // Either input zero or subnormal
    logic                                          is_zero;
  } side_t;

  // Payload between unpack, the steps and rounding
  typedef struct packed {
    logic [fp_format_pkg::mant_bits-1:0] mant_a;
    logic [fp_format_pkg::mant_bits-1:0] mant_b;
    // Partial product sum, full product after the last step
    logic [fp_format_pkg::prod_bits-1:0] acc;
    side_t                               side;
  } mac_stage_t;

endpackage

`default_nettype wire

//--- fmul_unpack.sv
`timescale 1ns/100ps
`default_nettype none

// First pipeline stage
// Classifies the operands and resolves special cases
module fmul_unpack (
  input  wire logic                      i_clk,
  input  wire logic                      i_rst,
  input  wire logic                      i_valid,
  input  fp_format_pkg::fp32_t           i_a,
  input  fp_format_pkg::fp32_t           i_b,
  input  fmul_pipe_pkg::round_mode_e     i_rm,
  output logic                           o_valid,
  output fmul_pipe_pkg::mac_stage_t      o_stage
);

  import fp_format_pkg::*;
  import fmul_pipe_pkg::*;

  // Operand class, subnormals counted as zero
  typedef struct packed {
    logic zero;
    logic inf;
    logic nan;
    logic snan;
  } op_class_t;

  function automatic op_class_t classify(input fp32_t op);
    op_class_t c;
    c.zero = (op.exp == '0);
    c.inf  = (op.exp == exp_max) && (op.frac == '0);
    c.nan  = (op.exp == exp_max) && (op.frac != '0);
    // Quiet bit clear means signaling
    c.snan = c.nan && !op.frac[frac_bits-1];
    return c;
  endfunction

  op_class_t                      cls_a;
  op_class_t                      cls_b;
  logic                           res_sign;
  logic signed [exp_ext_bits-1:0] tent_exp;
  side_t                          side_d;
  mac_stage_t                     stage_d;

  assign cls_a    = classify(i_a);
  assign cls_b    = classify(i_b);
  assign res_sign = i_a.sign ^ i_b.sign;

  // Biased sum minus one bias, wraps correctly into the signed width
  assign tent_exp = exp_ext_bits'(i_a.exp) + exp_ext_bits'(i_b.exp)
                  - exp_ext_bits'(exp_bias);

  // ====================
  // Special cases
  // ====================
  always_comb begin
    side_d         = '0;
    side_d.sign    = res_sign;
    side_d.exp     = tent_exp;
    side_d.rm      = i_rm;
    side_d.is_zero = cls_a.zero | cls_b.zero;
    if (cls_a.nan || cls_b.nan) begin
      // Any NaN, invalid only when signaling
      side_d.is_special      = 1'b1;
      side_d.special_result  = canonical_nan;
      side_d.special_invalid = cls_a.snan | cls_b.snan;
    end else if ((cls_a.inf && cls_b.zero) || (cls_a.zero && cls_b.inf)) begin
      side_d.is_special      = 1'b1;
      side_d.special_result  = canonical_nan;
      side_d.special_invalid = 1'b1;
    end else if (cls_a.inf || cls_b.inf) begin
      // Infinity times finite nonzero
      side_d.is_special     = 1'b1;
      side_d.special_result = '{sign: res_sign, exp: exp_max, frac: '0};
    end
    // Plain zero case handled downstream through is_zero
  end

  // Hidden bit only for normal operands
  always_comb begin
    stage_d.mant_a = {!cls_a.zero, i_a.frac};
    stage_d.mant_b = {!cls_b.zero, i_b.frac};
    stage_d.acc    = '0;
    stage_d.side   = side_d;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_stage <= stage_d;
    end
  end

endmodule

`default_nettype wire

//--- fmul_mac_step.sv
`timescale 1ns/100ps
`default_nettype none

// One multiply-accumulate step of the mantissa product
// Adds mant_a times one slice of mant_b into the accumulator
module fmul_mac_step #(
  parameter int STEP_INDEX = 0
) (
  input  wire logic                      i_clk,
  input  wire logic                      i_rst,
  input  wire logic                      i_valid,
  input  fmul_pipe_pkg::mac_stage_t      i_stage,
  output logic                           o_valid,
  output fmul_pipe_pkg::mac_stage_t      o_stage
);

  import fp_format_pkg::*;
  import fmul_pipe_pkg::*;

  // Bit position of this step's slice
  localparam int slice_lsb = STEP_INDEX * slice_bits;

  logic [slice_bits-1:0]           b_slice;
  logic [mant_bits+slice_bits-1:0] partial;
  logic [prod_bits-1:0]            partial_shifted;
  mac_stage_t                      stage_d;

  assign b_slice = i_stage.mant_b[slice_lsb +: slice_bits];

  // 24x6 partial product
  assign partial = i_stage.mant_a * b_slice;

  // Align to the slice weight, top step lands exactly on bit 47
  assign partial_shifted = prod_bits'(partial) << slice_lsb;

  // Mantissas and side band pass through
  always_comb begin
    stage_d     = i_stage;
    stage_d.acc = i_stage.acc + partial_shifted;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_stage <= stage_d;
    end
  end

endmodule

`default_nettype wire

//--- fmul_round.sv
`timescale 1ns/100ps
`default_nettype none

// Final two pipeline stages
// Normalize and decide rounding, then round and assemble result and flags
module fmul_round (
  input  wire logic                      i_clk,
  input  wire logic                      i_rst,
  input  wire logic                      i_valid,
  input  fmul_pipe_pkg::mac_stage_t      i_stage,
  output logic                           o_valid,
  output fp_format_pkg::fp32_t           o_result,
  output fp_format_pkg::fp_flags_t       o_flags
);

  import fp_format_pkg::*;
  import fmul_pipe_pkg::*;

  // Payload between the two rounding stages
  typedef struct packed {
    logic [mant_bits-1:0]           mant;
    logic signed [exp_ext_bits-1:0] exp;
    logic                           round_up;
    logic                           inexact;
    side_t                          side;
  } round_s1_t;

  // ====================
  // Stage 1
  // ====================

  logic [prod_bits-1:0]           prod;
  logic [mant_bits-1:0]           norm_mant;
  logic signed [exp_ext_bits-1:0] norm_exp;
  logic                           guard_bit;
  logic                           round_bit;
  logic                           sticky_bit;
  logic                           lost;
  logic                           rnd_up;
  round_s1_t                      s1_d;
  round_s1_t                      s1_q;
  logic                           s1_valid;

  assign prod = i_stage.acc;

  // Product of two normal mantissas lies in [1, 4) and needs at most a one-bit shift
  always_comb begin
    if (prod[prod_bits-1]) begin
      norm_mant  = prod[prod_bits-1 -: mant_bits];
      norm_exp   = i_stage.side.exp + exp_ext_bits'(1);
      guard_bit  = prod[mant_bits-1];
      round_bit  = prod[mant_bits-2];
      sticky_bit = |prod[mant_bits-3:0];
    end else begin
      norm_mant  = prod[prod_bits-2 -: mant_bits];
      norm_exp   = i_stage.side.exp;
      guard_bit  = prod[mant_bits-2];
      round_bit  = prod[mant_bits-3];
      sticky_bit = |prod[mant_bits-4:0];
    end
  end

  assign lost = guard_bit | round_bit | sticky_bit;

  // Round-up decision per mode
  always_comb begin
    case (i_stage.side.rm)
      rtz:     rnd_up = 1'b0;
      rdn:     rnd_up = lost & i_stage.side.sign;
      rup:     rnd_up = lost & !i_stage.side.sign;
      rmm:     rnd_up = guard_bit;
      // RNE and unused codes 5 to 7
      default: rnd_up = guard_bit & (round_bit | sticky_bit | norm_mant[0]);
    endcase
  end

  always_comb begin
    s1_d.mant     = norm_mant;
    s1_d.exp      = norm_exp;
    s1_d.round_up = rnd_up;
    s1_d.inexact  = lost;
    s1_d.side     = i_stage.side;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      s1_q <= s1_d;
    end
  end

  // ====================
  // Stage 2
  // ====================

  logic [mant_bits:0]             mant_inc;
  logic                           mant_carry;
  logic signed [exp_ext_bits-1:0] exp_post;
  logic                           ovf_to_inf;
  fp32_t                          result_d;
  fp_flags_t                      flags_d;

  // Carry out means 1.111..1 rounded up to 10.000..0
  assign mant_inc   = {1'b0, s1_q.mant} + (mant_bits + 1)'(s1_q.round_up);
  assign mant_carry = mant_inc[mant_bits];
  assign exp_post   = s1_q.exp + $signed({{(exp_ext_bits - 1){1'b0}}, mant_carry});

  // Infinity or largest finite on overflow
  always_comb begin
    case (s1_q.side.rm)
      rtz:     ovf_to_inf = 1'b0;
      rdn:     ovf_to_inf = s1_q.side.sign;
      rup:     ovf_to_inf = !s1_q.side.sign;
      default: ovf_to_inf = 1'b1;
    endcase
  end

  always_comb begin
    flags_d = '0;
    if (s1_q.side.is_special) begin
      // NaN and infinity results win over everything
      result_d   = s1_q.side.special_result;
      flags_d.nv = s1_q.side.special_invalid;
    end else if (s1_q.side.is_zero) begin
      // Exact signed zero
      result_d = '{sign: s1_q.side.sign, exp: '0, frac: '0};
    end else if (s1_q.exp < 1) begin
      // Tiny result flushed to signed zero
      result_d   = '{sign: s1_q.side.sign, exp: '0, frac: '0};
      flags_d.uf = 1'b1;
      flags_d.nx = 1'b1;
    end else if (exp_post >= 255) begin
      flags_d.of = 1'b1;
      flags_d.nx = 1'b1;
      if (ovf_to_inf) begin
        result_d = '{sign: s1_q.side.sign, exp: exp_max, frac: '0};
      end else begin
        result_d = {s1_q.side.sign, max_finite_mag};
      end
    end else begin
      // After a carry the fraction field is all zero anyway
      result_d.sign = s1_q.side.sign;
      result_d.exp  = exp_post[exp_bits-1:0];
      result_d.frac = mant_inc[frac_bits-1:0];
      flags_d.nx    = s1_q.inexact;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s1_valid) begin
      o_result <= result_d;
      o_flags  <= flags_d;
    end
  end

endmodule

`default_nettype wire

//--- fmul_top.sv
`timescale 1ns/100ps
`default_nettype none

// Pipelined single-precision multiplier, FMUL.S
// One operation per cycle, result fmul_latency cycles later
module fmul_top (
  input  wire logic                      i_clk,
  input  wire logic                      i_rst,
  input  wire logic                      i_valid,
  input  fp_format_pkg::fp32_t           i_a,
  input  fp_format_pkg::fp32_t           i_b,
  input  fmul_pipe_pkg::round_mode_e     i_rm,
  output logic                           o_valid,
  output fp_format_pkg::fp32_t           o_result,
  output fp_format_pkg::fp_flags_t       o_flags
);

  import fmul_pipe_pkg::*;

  // Entry 0 from unpack, entry mac_steps holds the full product
  logic [mac_steps:0] chain_valid;
  mac_stage_t         chain_stage [0:mac_steps];

  fmul_unpack u_unpack (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_a     (i_a),
    .i_b     (i_b),
    .i_rm    (i_rm),
    .o_valid (chain_valid[0]),
    .o_stage (chain_stage[0])
  );

  // Step k consumes mant_b bits from k*slice_bits upward
  for (genvar k = 0; k < mac_steps; k++) begin : g_step
    fmul_mac_step #(
      .STEP_INDEX (k)
    ) u_step (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_valid (chain_valid[k]),
      .i_stage (chain_stage[k]),
      .o_valid (chain_valid[k+1]),
      .o_stage (chain_stage[k+1])
    );
  end

  fmul_round u_round (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_valid  (chain_valid[mac_steps]),
    .i_stage  (chain_stage[mac_steps]),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_flags  (o_flags)
  );

endmodule

`default_nettype wire

//--- fmul_props.sv
`timescale 1ns/100ps
`default_nettype none

// Timing and reset properties of the multiplier top level
module fmul_props (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  input  wire logic            i_valid,
  input  wire logic            i_out_valid,
  input  fp_format_pkg::fp32_t i_out_result
);

  import fmul_pipe_pkg::*;

  // Low until the first reset edge
  logic rst_seen = 1'b0;
  // Cycles since reset released, saturates at the latency
  int   since_rst = 0;

  always @(posedge i_clk) begin
    if (i_rst) begin
      rst_seen  <= 1'b1;
      since_rst <= 0;
    end else if (since_rst < fmul_latency) begin
      since_rst <= since_rst + 1;
    end
  end

  // Quiet through reset and while the pipeline refills
  a_reset_quiet: assert property (@(posedge i_clk)
    (rst_seen && since_rst < fmul_latency) |-> !i_out_valid)
    else $error("o_valid high during reset or the refill window");

  // Fixed latency, one result per issued operation
  a_valid_delay: assert property (@(posedge i_clk)
    (since_rst == fmul_latency) |-> (i_out_valid == $past(i_valid, fmul_latency)))
    else $error("o_valid does not follow i_valid by the pipeline latency");

  a_result_known: assert property (@(posedge i_clk)
    i_out_valid |-> !$isunknown(i_out_result))
    else $error("o_result has unknown bits while o_valid is high");

endmodule

`default_nettype wire

//--- tb_fmul.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench for the pipelined FMUL.S unit
module tb_fmul;

  import fp_format_pkg::*;
  import fmul_pipe_pkg::*;

  // One directed operation with its expected response
  typedef struct packed {
    fp32_t       a;
    fp32_t       b;
    round_mode_e rm;
    fp32_t       res;
    fp_flags_t   flags;
  } vec_t;

  // Expected response of an operation still in flight
  typedef struct packed {
    int        id;
    int        issue;
    fp32_t     res;
    fp_flags_t flags;
  } expect_t;

  localparam int n_rand = 200;

  // Flag bits from MSB down are nv dz of uf nx
  localparam fp_flags_t fl_none = 5'b00000;
  localparam fp_flags_t fl_nv   = 5'b10000;
  localparam fp_flags_t fl_nx   = 5'b00001;
  localparam fp_flags_t fl_ofnx = 5'b00101;
  localparam fp_flags_t fl_ufnx = 5'b00011;

  // Operand encodings
  localparam logic [31:0] one_p0   = 32'h3F80_0000;
  localparam logic [31:0] two_p0   = 32'h4000_0000;
  localparam logic [31:0] nan_out  = 32'h7FC0_0000;
  localparam logic [31:0] one_ulp  = 32'h3F80_0001;
  localparam logic [31:0] max_fin  = 32'h7F7F_FFFF;

  logic        i_clk = 1'b0;
  logic        i_rst;
  logic        i_valid;
  fp32_t       i_a;
  fp32_t       i_b;
  round_mode_e i_rm;
  logic        o_valid;
  fp32_t       o_result;
  fp_flags_t   o_flags;

  vec_t        dir_q [$];
  expect_t     exp_q [$];
  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;
  int          op_count = 0;
  int          timeout_limit = 1000;

  fmul_top u_dut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_valid  (i_valid),
    .i_a      (i_a),
    .i_b      (i_b),
    .i_rm     (i_rm),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_flags  (o_flags)
  );

  bind fmul_top fmul_props u_props (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_out_valid  (o_valid),
    .i_out_result (o_result)
  );

  // 4 ns period
  always #2 i_clk = ~i_clk;

  // ====================
  // Helpers
  // ====================

  // Feedback taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // Exact conversion of a nonzero integer below 2^24
  function automatic fp32_t int_to_fp(input logic sign, input logic [31:0] v);
    fp32_t f;
    int    msb;
    msb = 0;
    for (int i = 0; i < mant_bits; i++) begin
      if (v[i]) begin
        msb = i;
      end
    end
    f.sign = sign;
    f.exp  = exp_bits'(exp_bias + msb);
    // Hidden bit lands on bit 23 and drops out of the field
    f.frac = frac_bits'(v << (frac_bits - msb));
    return f;
  endfunction

  task automatic add_vec(input logic [31:0] a, input logic [31:0] b, input round_mode_e rm,
                         input logic [31:0] res, input fp_flags_t flags);
    vec_t v;
    v.a     = a;
    v.b     = b;
    v.rm    = rm;
    v.res   = res;
    v.flags = flags;
    dir_q.push_back(v);
  endtask

  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_result(input string name, input fp32_t exp_v, input fp32_t act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
      stop_run();
    end
  endtask

  task automatic check_flags(input string name, input fp_flags_t exp_v, input fp_flags_t act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp_v, act_v);
      stop_run();
    end
  endtask

  task automatic check_latency(input string name, input int exp_v, input int act_v);
    if (act_v != exp_v) begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
      stop_run();
    end
  endtask

  // Drive one operation, then step to 1 ns after the next edge
  task automatic issue_op(input fp32_t a, input fp32_t b, input round_mode_e rm,
                          input fp32_t res, input fp_flags_t flags);
    expect_t e;
    i_valid = 1'b1;
    i_a     = a;
    i_b     = b;
    i_rm    = rm;
    e.id    = op_count;
    e.issue = cycle_cnt;
    e.res   = res;
    e.flags = flags;
    exp_q.push_back(e);
    op_count++;
    @(posedge i_clk);
    #1;
  endtask

  task automatic load_table();
    // Special cases
    add_vec(32'hFFC1_2345, one_p0, rne, nan_out, fl_none);
    add_vec(32'h7F80_0001, one_p0, rne, nan_out, fl_nv);
    add_vec(32'h7F80_0000, 32'h8000_0000, rne, nan_out, fl_nv);
    add_vec(32'hFF80_0000, two_p0, rne, 32'hFF80_0000, fl_none);
    add_vec(32'h8000_0000, 32'h40A0_0000, rne, 32'h8000_0000, fl_none);
    add_vec(32'h8040_0000, 32'h4040_0000, rne, 32'h8000_0000, fl_none);
    // (1+2^-23)^2 leaves only 2^-46 below the lsb
    add_vec(one_ulp, one_ulp, rne, 32'h3F80_0002, fl_nx);
    add_vec(one_ulp, one_ulp, rtz, 32'h3F80_0002, fl_nx);
    add_vec(one_ulp, one_ulp, rdn, 32'h3F80_0002, fl_nx);
    add_vec(one_ulp, one_ulp, rup, 32'h3F80_0003, fl_nx);
    add_vec(one_ulp, one_ulp, rmm, 32'h3F80_0002, fl_nx);
    add_vec(32'hBF80_0001, one_ulp, rdn, 32'hBF80_0003, fl_nx);
    // Overflow
    add_vec(max_fin, two_p0, rne, 32'h7F80_0000, fl_ofnx);
    add_vec(max_fin, two_p0, rtz, max_fin, fl_ofnx);
    add_vec(32'hFF7F_FFFF, two_p0, rup, 32'hFF7F_FFFF, fl_ofnx);
    // 2^-100 times 2^-50 is far below the normal range
    add_vec(32'h0D80_0000, 32'h2680_0000, rne, 32'h0000_0000, fl_ufnx);
    add_vec(32'h8D80_0000, 32'h2680_0000, rne, 32'h8000_0000, fl_ufnx);
  endtask

  // ====================
  // Output monitor
  // ====================
  always @(posedge i_clk) begin
    expect_t head;
    if (o_valid) begin
      if (exp_q.size() == 0) begin
        $display("o_valid went high at %0t with no operation in flight", $time);
        stop_run();
      end else begin
        head = exp_q.pop_front();
        check_result($sformatf("o_result op %0d", head.id), head.res, o_result);
        check_flags($sformatf("o_flags op %0d", head.id), head.flags, o_flags);
        check_latency($sformatf("latency op %0d", head.id), fmul_latency,
                      cycle_cnt - head.issue);
      end
    end
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout after %0d cycles, %0d results missing", cycle_cnt, exp_q.size());
      stop_run();
    end
  end

  // ====================
  // Stimulus
  // ====================
  initial begin
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] sa;
    logic [31:0] sb;
    logic [31:0] r;
    i_rst      = 1'b1;
    i_valid    = 1'b0;
    i_a        = '0;
    i_b        = '0;
    i_rm       = rne;
    lfsr_state = 32'h4373_5846;
    load_table();
    timeout_limit = dir_q.size() + n_rand + fmul_latency + 20;
    repeat (5) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    foreach (dir_q[k]) begin
      issue_op(dir_q[k].a, dir_q[k].b, dir_q[k].rm, dir_q[k].res, dir_q[k].flags);
    end
    // Back-to-back exact products over all eight mode codes
    for (int n = 0; n < n_rand; n++) begin
      draw_bits(12, x);
      draw_bits(12, y);
      draw_bits(1, sa);
      draw_bits(1, sb);
      draw_bits(3, r);
      if (x == 0) begin
        x = 1;
      end
      if (y == 0) begin
        y = 1;
      end
      issue_op(int_to_fp(sa[0], x), int_to_fp(sb[0], y), round_mode_e'(r[2:0]),
               int_to_fp(sa[0] ^ sb[0], x * y), fl_none);
    end
    i_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (2) @(posedge i_clk);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
fp_format_pkg.sv
fmul_pipe_pkg.sv
fmul_unpack.sv
fmul_mac_step.sv
fmul_round.sv
fmul_top.sv
fmul_props.sv
tb_fmul.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FMUL.S testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fmul \
  -f verilog.f \
  -Mdir obj_dir \
  -o sim_fmul

./obj_dir/sim_fmul
